//--- source/mem_sec_pkg.sv
// secure memory access controller
// shared widths, reset partition and the opcode and verdict encodings
// used by the check, data and response stages

package mem_sec_pkg;

	//----------------------------------------------------------
	// field widths and sizes
	//----------------------------------------------------------

	// word address into the on-chip memory
	localparam int addr_w = 10;

	// data word
	localparam int data_w = 32;

	// request tag, echoed back unchanged
	localparam int opaque_w = 8;

	// memory depth in words
	localparam int mem_words = 1024;

	//----------------------------------------------------------
	// partition control
	//----------------------------------------------------------

	// boundary between low and high region after reset
	localparam logic [addr_w-1:0] par_reset = 10'h300;

	// secure writes to this word move the boundary
	localparam logic [addr_w-1:0] cfg_addr = '0;

	//----------------------------------------------------------
	// encodings
	//----------------------------------------------------------

	typedef enum logic [0:0] {
		op_read  = 1'b0,
		op_write = 1'b1
	} mem_op_e;

	// outcome of the policy check, carried down the pipeline
	typedef enum logic [1:0] {
		verdict_access  = 2'd0,
		verdict_deny    = 2'd1,
		verdict_set_par = 2'd2
	} mem_verdict_e;

endpackage

//--- source/mem_sec_check.sv
// secure memory check stage
// holds the partition register and judges every request against
// the domain and declassify policy, one request per cycle

`timescale 1ns/1ps

module mem_sec_check (
	input  logic clk,
	input  logic reset,

	// request side
	input  logic req_val,
	output logic req_rdy,
	input  mem_sec_pkg::mem_op_e req_op,
	input  logic [mem_sec_pkg::opaque_w-1:0] req_opaque,
	input  logic [mem_sec_pkg::addr_w-1:0] req_addr,
	input  logic [mem_sec_pkg::data_w-1:0] req_data,
	input  logic req_domain,
	input  logic req_declass,

	// toward the data stage
	output logic out_val,
	input  logic out_rdy,
	output mem_sec_pkg::mem_op_e out_op,
	output logic [mem_sec_pkg::opaque_w-1:0] out_opaque,
	output logic [mem_sec_pkg::addr_w-1:0] out_addr,
	output logic [mem_sec_pkg::data_w-1:0] out_data,
	output logic out_domain,
	output mem_sec_pkg::mem_verdict_e out_verdict,
	output logic out_low_region
);

	import mem_sec_pkg::*;

	//----------------------------------------------------------
	// handshake
	//----------------------------------------------------------

	logic accept;

	// register free, or its content leaves this cycle
	assign req_rdy = !out_val || out_rdy;
	assign accept  = req_val && req_rdy;

	//----------------------------------------------------------
	// policy
	//----------------------------------------------------------

	logic [addr_w-1:0] par_q;
	logic              addr_low;
	logic              addr_cfg;
	mem_verdict_e      verdict;

	assign addr_low = req_addr < par_q;
	assign addr_cfg = req_addr == cfg_addr;

	always_comb begin
		verdict = verdict_deny;
		if (!req_domain) begin
			// normal domain only sees the low region
			if (addr_cfg) begin
				verdict = verdict_deny;
			end else if (addr_low) begin
				verdict = verdict_access;
			end else begin
				verdict = verdict_deny;
			end
		end else begin
			// secure domain, declass must match the region
			if (addr_cfg) begin
				verdict = verdict_set_par;
			end else if (addr_low) begin
				if (req_declass) begin
					verdict = verdict_deny;
				end else begin
					verdict = verdict_access;
				end
			end else begin
				if (req_declass) begin
					verdict = verdict_access;
				end else begin
					verdict = verdict_deny;
				end
			end
		end
	end

	//----------------------------------------------------------
	// partition register and stage valid
	//----------------------------------------------------------

	always_ff @(posedge clk) begin
		if (reset) begin
			par_q   <= par_reset;
			out_val <= 1'b0;
		end else begin
			// next request already sees the new boundary
			if (accept && verdict == verdict_set_par) begin
				par_q <= req_data[addr_w-1:0];
			end
			if (req_rdy) begin
				out_val <= req_val;
			end
		end
	end

	// payload, loaded on acceptance only
	always_ff @(posedge clk) begin
		if (accept) begin
			out_op         <= req_op;
			out_opaque     <= req_opaque;
			out_addr       <= req_addr;
			out_data       <= req_data;
			out_domain     <= req_domain;
			out_verdict    <= verdict;
			out_low_region <= addr_low;
		end
	end

endmodule

//--- source/mem_data_stage.sv
// secure memory data stage
// owns the word memory and carries out the reads and writes that
// the check stage allowed

`timescale 1ns/1ps

module mem_data_stage (
	input  logic clk,
	input  logic reset,

	// from the check stage
	input  logic in_val,
	output logic in_rdy,
	input  mem_sec_pkg::mem_op_e in_op,
	input  logic [mem_sec_pkg::opaque_w-1:0] in_opaque,
	input  logic [mem_sec_pkg::addr_w-1:0] in_addr,
	input  logic [mem_sec_pkg::data_w-1:0] in_data,
	input  logic in_domain,
	input  mem_sec_pkg::mem_verdict_e in_verdict,
	input  logic in_low_region,

	// toward the response stage
	output logic out_val,
	input  logic out_rdy,
	output mem_sec_pkg::mem_op_e out_op,
	output logic [mem_sec_pkg::opaque_w-1:0] out_opaque,
	output logic out_domain,
	output mem_sec_pkg::mem_verdict_e out_verdict,
	output logic out_low_region,
	output logic [mem_sec_pkg::data_w-1:0] out_rd_data
);

	import mem_sec_pkg::*;

	//----------------------------------------------------------
	// handshake
	//----------------------------------------------------------

	logic accept;
	logic do_read;
	logic do_write;

	assign in_rdy = !out_val || out_rdy;
	assign accept = in_val && in_rdy;

	// memory touched on acceptance only, a stall never replays
	assign do_write = accept && in_verdict == verdict_access && in_op == op_write;
	assign do_read  = in_verdict == verdict_access && in_op == op_read;

	//----------------------------------------------------------
	// word memory
	//----------------------------------------------------------

	logic [data_w-1:0] mem [mem_words];

	always_ff @(posedge clk) begin
		if (do_write) begin
			mem[in_addr] <= in_data;
		end
	end

	//----------------------------------------------------------
	// output register
	//----------------------------------------------------------

	always_ff @(posedge clk) begin
		if (reset) begin
			out_val <= 1'b0;
		end else if (in_rdy) begin
			out_val <= in_val;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			out_op         <= in_op;
			out_opaque     <= in_opaque;
			out_domain     <= in_domain;
			out_verdict    <= in_verdict;
			out_low_region <= in_low_region;
			// writes, denials and partition updates return zero
			if (do_read) begin
				out_rd_data <= mem[in_addr];
			end else begin
				out_rd_data <= '0;
			end
		end
	end

endmodule

//--- source/mem_resp_stage.sv
// secure memory response stage
// forms the response fields, security level and insecure flag,
// and holds them while the requester is not ready

`timescale 1ns/1ps

module mem_resp_stage (
	input  logic clk,
	input  logic reset,

	// from the data stage
	input  logic in_val,
	output logic in_rdy,
	input  mem_sec_pkg::mem_op_e in_op,
	input  logic [mem_sec_pkg::opaque_w-1:0] in_opaque,
	input  logic in_domain,
	input  mem_sec_pkg::mem_verdict_e in_verdict,
	input  logic in_low_region,
	input  logic [mem_sec_pkg::data_w-1:0] in_rd_data,

	// response side
	output logic resp_val,
	input  logic resp_rdy,
	output mem_sec_pkg::mem_op_e resp_op,
	output logic [mem_sec_pkg::opaque_w-1:0] resp_opaque,
	output logic [mem_sec_pkg::data_w-1:0] resp_data,
	output logic resp_sec_level,
	output logic resp_insecure
);

	import mem_sec_pkg::*;

	//----------------------------------------------------------
	// handshake
	//----------------------------------------------------------

	logic accept;

	assign in_rdy = !resp_val || resp_rdy;
	assign accept = in_val && in_rdy;

	//----------------------------------------------------------
	// response fields
	//----------------------------------------------------------

	logic              is_access;
	logic              sec_level;
	logic              insecure;
	logic [data_w-1:0] data;

	assign is_access = in_verdict == verdict_access;
	assign insecure  = in_verdict == verdict_deny;

	always_comb begin
		if (is_access) begin
			// only a normal access to the low region stays at level 0
			sec_level = !(in_low_region && !in_domain);
		end else begin
			sec_level = in_domain;
		end
	end

	// data only for reads that reached memory
	always_comb begin
		if (is_access && in_op == op_read) begin
			data = in_rd_data;
		end else begin
			data = '0;
		end
	end

	//----------------------------------------------------------
	// output register
	//----------------------------------------------------------

	always_ff @(posedge clk) begin
		if (reset) begin
			resp_val <= 1'b0;
		end else if (in_rdy) begin
			resp_val <= in_val;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			resp_op        <= in_op;
			resp_opaque    <= in_opaque;
			resp_data      <= data;
			resp_sec_level <= sec_level;
			resp_insecure  <= insecure;
		end
	end

endmodule

//--- source/mem_sec_top.sv
// secure memory access controller top level
// chains check, data and response stages into a three deep pipeline

`timescale 1ns/1ps

module mem_sec_top (
	input  logic clk,
	input  logic reset,

	// request side
	input  logic req_val,
	output logic req_rdy,
	input  mem_sec_pkg::mem_op_e req_op,
	input  logic [mem_sec_pkg::opaque_w-1:0] req_opaque,
	input  logic [mem_sec_pkg::addr_w-1:0] req_addr,
	input  logic [mem_sec_pkg::data_w-1:0] req_data,
	input  logic req_domain,
	input  logic req_declass,

	// response side
	output logic resp_val,
	input  logic resp_rdy,
	output mem_sec_pkg::mem_op_e resp_op,
	output logic [mem_sec_pkg::opaque_w-1:0] resp_opaque,
	output logic [mem_sec_pkg::data_w-1:0] resp_data,
	output logic resp_sec_level,
	output logic resp_insecure
);

	import mem_sec_pkg::*;

	//----------------------------------------------------------
	// check to data link
	//----------------------------------------------------------

	logic                chk_val;
	logic                chk_rdy;
	mem_op_e             chk_op;
	logic [opaque_w-1:0] chk_opaque;
	logic [addr_w-1:0]   chk_addr;
	logic [data_w-1:0]   chk_data;
	logic                chk_domain;
	mem_verdict_e        chk_verdict;
	logic                chk_low_region;

	//----------------------------------------------------------
	// data to response link
	//----------------------------------------------------------

	logic                dat_val;
	logic                dat_rdy;
	mem_op_e             dat_op;
	logic [opaque_w-1:0] dat_opaque;
	logic                dat_domain;
	mem_verdict_e        dat_verdict;
	logic                dat_low_region;
	logic [data_w-1:0]   dat_rd_data;

	mem_sec_check check0 (
		.clk(clk), .reset(reset),
		.req_val(req_val), .req_rdy(req_rdy), .req_op(req_op),
		.req_opaque(req_opaque), .req_addr(req_addr), .req_data(req_data),
		.req_domain(req_domain), .req_declass(req_declass),
		.out_val(chk_val), .out_rdy(chk_rdy), .out_op(chk_op),
		.out_opaque(chk_opaque), .out_addr(chk_addr), .out_data(chk_data),
		.out_domain(chk_domain), .out_verdict(chk_verdict),
		.out_low_region(chk_low_region)
	);

	mem_data_stage data0 (
		.clk(clk), .reset(reset),
		.in_val(chk_val), .in_rdy(chk_rdy), .in_op(chk_op),
		.in_opaque(chk_opaque), .in_addr(chk_addr), .in_data(chk_data),
		.in_domain(chk_domain), .in_verdict(chk_verdict),
		.in_low_region(chk_low_region),
		.out_val(dat_val), .out_rdy(dat_rdy), .out_op(dat_op),
		.out_opaque(dat_opaque), .out_domain(dat_domain),
		.out_verdict(dat_verdict), .out_low_region(dat_low_region),
		.out_rd_data(dat_rd_data)
	);

	mem_resp_stage resp0 (
		.clk(clk), .reset(reset),
		.in_val(dat_val), .in_rdy(dat_rdy), .in_op(dat_op),
		.in_opaque(dat_opaque), .in_domain(dat_domain),
		.in_verdict(dat_verdict), .in_low_region(dat_low_region),
		.in_rd_data(dat_rd_data),
		.resp_val(resp_val), .resp_rdy(resp_rdy), .resp_op(resp_op),
		.resp_opaque(resp_opaque), .resp_data(resp_data),
		.resp_sec_level(resp_sec_level), .resp_insecure(resp_insecure)
	);

endmodule

//--- bench/tb_mem_sec_top.sv
// testbench for the secure memory access controller
// reference model of partition and memory, directed and random
// traffic, concurrent assertions on every response

`timescale 1ns/1ps

module tb_mem_sec_top;

	import mem_sec_pkg::*;

	localparam int n_directed = 41;
	localparam int n_random   = 150;
	localparam int max_cycles = 4 * (n_directed + 2 * n_random) + 200;
	localparam logic [addr_w-1:0] win_base = 10'h1f8;

	typedef struct packed {
		logic                op;
		logic [opaque_w-1:0] opaque;
		logic [data_w-1:0]   data;
		logic                sec;
		logic                insec;
		logic [31:0]         acc_edge;
	} resp_t;

	logic clk, reset;
	logic req_val, req_rdy, req_domain, req_declass;
	mem_op_e req_op;
	logic [opaque_w-1:0] req_opaque;
	logic [addr_w-1:0] req_addr;
	logic [data_w-1:0] req_data;
	logic resp_val, resp_rdy, resp_sec_level, resp_insecure;
	mem_op_e resp_op;
	logic [opaque_w-1:0] resp_opaque;
	logic [data_w-1:0] resp_data;

	// reference model state
	logic [addr_w-1:0] m_par;
	logic [data_w-1:0] m_mem [mem_words];
	resp_t exp_q [$];

	// head of the queue for the response now on the bus
	logic exp_ok, exp_op, exp_sec, exp_insec;
	logic [opaque_w-1:0] exp_opaque;
	logic [data_w-1:0] exp_data;

	logic [31:0] rng_state;
	logic [opaque_w-1:0] tag;
	logic lat_check, rdy_random;
	int cycles, err_count, check_count, req_count, test_count, req_base, err_base;

	mem_sec_top dut0 (.*);

	always #50 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= max_cycles) begin
			$display("timeout: run passed %0d cycles, %0d responses still outstanding",
				max_cycles, exp_q.size());
			$display("ERRORS FOUND");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift32();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	// policy as a table of domain, region and declass
	function automatic mem_verdict_e judge(input logic domain, input logic declass,
			input logic [addr_w-1:0] addr);
		if (addr == cfg_addr) begin
			return domain ? verdict_set_par : verdict_deny;
		end
		if (!domain) begin
			return (addr < m_par) ? verdict_access : verdict_deny;
		end
		// on the secure side declass set means the upper region
		return ((addr >= m_par) == declass) ? verdict_access : verdict_deny;
	endfunction

	function automatic logic [data_w-1:0] fill_word(input logic [addr_w-1:0] addr);
		return {6'h2a, addr, ~addr, 6'h15};
	endfunction

	//----------------------------------------------------------
	// response checks
	//----------------------------------------------------------

	// fields in order op, data, sec level, insecure
	assert property (@(posedge clk) disable iff (reset)
		resp_val && resp_rdy |-> exp_ok && resp_op == exp_op && resp_opaque == exp_opaque
			&& resp_data == exp_data && resp_sec_level == exp_sec
			&& resp_insecure == exp_insec)
	else begin
		$display("error at %0t: tag %h expected %0d %h %0d %0d, got %0d %h %0d %0d",
			$time, exp_opaque, exp_op, exp_data, exp_sec, exp_insec, $sampled(resp_op),
			$sampled(resp_data), $sampled(resp_sec_level), $sampled(resp_insecure));
		err_count++;
	end

	assert property (@(posedge clk) disable iff (reset)
		resp_val && !resp_rdy |=> resp_val && $stable(resp_opaque) && $stable(resp_data)
			&& $stable(resp_op) && $stable(resp_sec_level) && $stable(resp_insecure))
	else begin
		$display("error at %0t: response tag %h changed while stalled", $time, resp_opaque);
		err_count++;
	end

	// monitor sampled well after the falling edge
	always @(negedge clk) begin
		resp_t head;
		resp_t e;
		mem_verdict_e v;
		#10;
		if (!reset) begin
			if (resp_val && resp_rdy) begin
				if (exp_q.size() == 0) begin
					$display("unexpected response with tag %h at %0t, no request outstanding",
						resp_opaque, $time);
					exp_ok = 1'b0;
					err_count++;
				end else begin
					head = exp_q.pop_front();
					exp_ok = 1'b1;
					exp_op = head.op;
					exp_opaque = head.opaque;
					exp_data = head.data;
					exp_sec = head.sec;
					exp_insec = head.insec;
					check_count++;
					// transfer happens at the coming rising edge
					if (lat_check) begin
						assert (cycles + 1 - head.acc_edge == 3) else begin
							$display("error at %0t: tag %h took %0d cycles, expected 3",
								$time, head.opaque, cycles + 1 - head.acc_edge);
							err_count++;
						end
					end
				end
			end
			if (req_val && req_rdy) begin
				v = judge(req_domain, req_declass, req_addr);
				e.op = req_op;
				e.opaque = req_opaque;
				e.data = '0;
				e.insec = v == verdict_deny;
				e.sec = req_domain;
				e.acc_edge = cycles + 1;
				if (v == verdict_access) begin
					// level 0 only for a normal-domain access in the low region
					if (!req_domain && req_addr < m_par) begin
						e.sec = 1'b0;
					end else begin
						e.sec = 1'b1;
					end
					if (req_op == op_write) begin
						m_mem[req_addr] = req_data;
					end else begin
						e.data = m_mem[req_addr];
					end
				end else if (v == verdict_set_par) begin
					m_par = req_data[addr_w-1:0];
				end
				exp_q.push_back(e);
			end
		end
	end

	//----------------------------------------------------------
	// stimulus helpers
	//----------------------------------------------------------

	task automatic next_cycle();
		@(negedge clk);
		resp_rdy = rdy_random ? (xorshift32() % 4 != 0) : 1'b1;
	endtask

	task automatic idle_cycle();
		next_cycle();
		req_val = 1'b0;
	endtask

	task automatic send_req(input mem_op_e op, input logic [addr_w-1:0] addr,
			input logic [data_w-1:0] data, input logic domain, input logic declass);
		next_cycle();
		req_val = 1'b1;
		req_op = op;
		req_opaque = tag;
		req_addr = addr;
		req_data = data;
		req_domain = domain;
		req_declass = declass;
		tag++;
		req_count++;
		#10;
		while (!req_rdy) begin
			next_cycle();
			#10;
		end
	endtask

	// normal domain below the boundary, secure declassified above it
	task automatic allowed_write(input logic [addr_w-1:0] addr, input logic [data_w-1:0] data);
		if (addr < m_par) begin
			send_req(op_write, addr, data, 1'b0, 1'b0);
		end else begin
			send_req(op_write, addr, data, 1'b1, 1'b1);
		end
	endtask

	task automatic random_req();
		logic [31:0] r;
		logic [addr_w-1:0] addr;
		logic [data_w-1:0] data;
		r = xorshift32();
		if (r[2:0] == 3'd0) begin
			// boundary stays inside the filled window
			addr = cfg_addr;
			data = win_base + r[7:3] % 17;
		end else begin
			addr = win_base + r[6:3];
			data = xorshift32();
		end
		send_req(r[8] ? op_write : op_read, addr, data, r[9], r[10]);
	endtask

	task automatic finish_test(input string name);
		idle_cycle();
		while (exp_q.size() != 0) begin
			next_cycle();
		end
		repeat (2) next_cycle();
		$display("test %s: %0d requests, %0d errors", name, req_count - req_base,
			err_count - err_base);
		req_base = req_count;
		err_base = err_count;
		test_count++;
	endtask

	//----------------------------------------------------------
	// test sequence
	//----------------------------------------------------------

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		req_val = 1'b0;
		req_op = op_read;
		req_opaque = '0;
		req_addr = '0;
		req_data = '0;
		req_domain = 1'b0;
		req_declass = 1'b0;
		resp_rdy = 1'b1;
		rng_state = 32'd33962;
		tag = '0;
		m_par = par_reset;
		{lat_check, rdy_random, exp_ok, exp_op, exp_sec, exp_insec} = '0;
		exp_opaque = '0;
		exp_data = '0;
		{cycles, err_count, check_count, req_count, test_count, req_base, err_base} = '0;
		repeat (2) @(posedge clk);
		next_cycle();
		reset = 1'b0;
		#10;
		assert (!resp_val && req_rdy) else begin
			$display("error at %0t: after reset resp_val %b req_rdy %b", $time, resp_val,
				req_rdy);
			err_count++;
		end

		// boundary right at 10'h300
		send_req(op_write, 10'h2ff, xorshift32(), 1'b0, 1'b0);
		send_req(op_write, 10'h300, xorshift32(), 1'b0, 1'b0);
		finish_test("reset_state");

		send_req(op_write, 10'h010, xorshift32(), 1'b0, 1'b0);
		send_req(op_write, 10'h011, xorshift32(), 1'b0, 1'b0);
		send_req(op_write, 10'h020, xorshift32(), 1'b0, 1'b0);
		send_req(op_read, 10'h010, '0, 1'b0, 1'b0);
		send_req(op_read, 10'h011, '0, 1'b0, 1'b0);
		send_req(op_read, 10'h020, '0, 1'b0, 1'b0);
		send_req(op_read, 10'h2ff, '0, 1'b0, 1'b0);
		finish_test("normal_access");

		send_req(op_write, 10'h3a0, 32'h5a5a_0001, 1'b1, 1'b1);
		send_req(op_write, cfg_addr, 32'h0000_0100, 1'b0, 1'b0);
		send_req(op_write, 10'h3a0, 32'hdead_0001, 1'b0, 1'b0);
		send_req(op_write, 10'h010, 32'hdead_0002, 1'b1, 1'b1);
		send_req(op_write, 10'h3a0, 32'hdead_0003, 1'b1, 1'b0);
		send_req(op_read, 10'h010, '0, 1'b0, 1'b0);
		send_req(op_read, 10'h3a0, '0, 1'b1, 1'b1);
		finish_test("denials");

		send_req(op_write, 10'h3c0, xorshift32(), 1'b1, 1'b1);
		send_req(op_read, 10'h3c0, '0, 1'b1, 1'b1);
		send_req(op_write, 10'h030, xorshift32(), 1'b1, 1'b0);
		send_req(op_read, 10'h030, '0, 1'b1, 1'b0);
		finish_test("secure_access");

		// new boundary applies to the very next request
		send_req(op_write, cfg_addr, 32'h0000_0200, 1'b1, 1'b0);
		send_req(op_read, 10'h010, '0, 1'b0, 1'b0);
		send_req(op_write, 10'h250, 32'h0bad_0250, 1'b0, 1'b0);
		send_req(op_write, 10'h250, 32'h600d_0250, 1'b1, 1'b1);
		send_req(op_read, 10'h250, '0, 1'b1, 1'b1);
		finish_test("partition_change");

		for (int i = 0; i < 16; i++) begin
			allowed_write(win_base + i, fill_word(win_base + i));
		end
		finish_test("window_fill");

		lat_check = 1'b1;
		repeat (n_random) random_req();
		finish_test("full_rate");
		lat_check = 1'b0;

		rdy_random = 1'b1;
		repeat (n_random) begin
			if (xorshift32() % 4 == 0) begin
				idle_cycle();
			end
			random_req();
		end
		finish_test("back_pressure");
		rdy_random = 1'b0;

		if (check_count != req_count) begin
			$display("response count wrong: %0d requests but %0d responses", req_count,
				check_count);
			err_count++;
		end
		$display("tests %0d, requests %0d, responses checked %0d, errors %0d", test_count,
			req_count, check_count, err_count);
		if (err_count == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

//--- src.f
source/mem_sec_pkg.sv
source/mem_sec_check.sv
source/mem_data_stage.sv
source/mem_resp_stage.sv
source/mem_sec_top.sv
bench/tb_mem_sec_top.sv

//--- Bender.yml
package:
  name: mem_sec

sources:
  - source/mem_sec_pkg.sv
  - source/mem_sec_check.sv
  - source/mem_data_stage.sv
  - source/mem_resp_stage.sv
  - source/mem_sec_top.sv
  - target: test
    files:
      - bench/tb_mem_sec_top.sv
